// File: Bender.yml
package:
  name: nes_lcd

sources:
  - nes_video_pkg.sv
  - raster_if.sv
  - frame_timer.sv
  - raster_sequencer.sv
  - nes_window_map.sv
  - nes_palette_rgb.sv
  - nes_lcd_top.sv
  - target: test
    files:
      - nes_lcd_chk.sv
      - tb_nes_lcd.sv

// File: frame_timer.sv
module frame_timer import nes_video_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic i_raster_done,
  output logic o_start
);

  logic [CNT_W-1:0] gap_cnt;
  logic             armed;    // counting towards the next raster
  logic             gap_end;

  assign gap_end = (gap_cnt == CNT_W'(FRAME_GAP - 1));

  // one cycle, on the last gap slot, so the raster starts right after it
  assign o_start = armed & gap_end;

  always_ff @(posedge clk) begin
    if (rst) begin
      gap_cnt <= '0;
      armed   <= 1'b1;        // first raster follows reset
    end else if (i_raster_done) begin
      gap_cnt <= '0;          // restart the gap from the raster end
      armed   <= 1'b1;
    end else if (armed) begin
      if (gap_end) begin
        gap_cnt <= '0;
        armed   <= 1'b0;      // wait for the sequencer
      end else begin
        gap_cnt <= gap_cnt + 1'b1;
      end
    end
  end

endmodule

// File: nes_lcd_chk.sv
module nes_lcd_chk import nes_video_pkg::*; (
  input logic             clk,
  input logic             rst,
  input logic [5:0]       i_sys_palette_idx,
  input logic [POS_W-1:0] o_nes_x,
  input logic [POS_W-1:0] o_nes_y,
  input logic [POS_W-1:0] o_nes_y_next,
  input logic             o_pix_pulse,
  input logic             o_vblank,
  input logic             o_video_hsync,
  input logic             o_sof_stb,
  input logic [2:0]       o_r,
  input logic [2:0]       o_g,
  input logic [1:0]       o_b
);
  timeunit 1ns;
  timeprecision 1ps;

  int         fail_cnt = 0;  // read by the testbench
  int         vb_len;        // cycles of the current vblank
  int         hs_len;        // cycles of the current hsync pulse
  int         hs_per;        // cycles since the last hsync rise, 0 in vblank
  int         sof_gap;
  logic       sof_seen;
  logic       hs_q;
  int         pix_cnt;       // pix pulses since the line started
  int         line_no;       // raster line, counted from the frame start
  logic [1:0] pulse_q;       // bit 1 marks the ppu answer cycle
  logic       known_idx;     // palette entries with a fixed expected colour
  logic [7:0] rgb;

  // pixel requests expected on one raster line
  function automatic int line_pixels(input int line);
    if (line >= Y_OFFSET && line < Y_OFFSET + IMAGE_HEIGHT)
      return IMAGE_WIDTH;
    return 0;
  endfunction

  function automatic logic [7:0] known_rgb(input logic [5:0] idx);
    case (idx)
      6'h00:   return {3'd3, 3'd3, 2'd1};
      6'h20:   return {3'd7, 3'd7, 2'd3};  // white
      default: return 8'h00;
    endcase
  endfunction

  assign rgb       = {o_r, o_g, o_b};
  assign known_idx = (i_sys_palette_idx == 6'h00) || (i_sys_palette_idx == 6'h20) ||
                     (i_sys_palette_idx == 6'h0d);

  always_ff @(posedge clk) begin
    if (rst) begin
      vb_len   <= 0;
      hs_len   <= 0;
      hs_per   <= 0;
      sof_gap  <= 0;
      sof_seen <= 1'b0;
      hs_q     <= 1'b0;
      pix_cnt  <= 0;
      line_no  <= 0;
      pulse_q  <= '0;
    end else begin
      hs_q    <= o_video_hsync;
      pulse_q <= {pulse_q[0], o_pix_pulse};
      vb_len  <= o_vblank ? vb_len + 1 : 0;
      hs_len  <= o_video_hsync ? hs_len + 1 : 0;
      if (o_vblank)
        hs_per <= 0;
      else if (o_video_hsync && !hs_q)
        hs_per <= 1;
      else if (hs_per != 0)
        hs_per <= hs_per + 1;
      if (o_sof_stb) begin
        sof_gap  <= 1;
        sof_seen <= 1'b1;
      end else begin
        sof_gap <= sof_gap + 1;
      end
      if (o_sof_stb)
        line_no <= -1;             // first hsync rise makes it line 0
      else if (o_video_hsync && !hs_q)
        line_no <= line_no + 1;
      if (o_video_hsync && !hs_q)
        pix_cnt <= 0;              // new line
      else if (o_pix_pulse)
        pix_cnt <= pix_cnt + 1;
    end
  end

  // outputs right after each reset cycle
  a_reset: assert property (@(posedge clk) rst |=>
      (!o_video_hsync && !o_sof_stb && !o_pix_pulse && rgb == 8'h00 && o_vblank))
    else begin
      $error("Mismatch at %0t: reset outputs hsync=%b sof=%b pix=%b rgb=%h vblank=%b, %s",
             $time, $sampled(o_video_hsync), $sampled(o_sof_stb), $sampled(o_pix_pulse),
             $sampled(rgb), $sampled(o_vblank), "exp 0 0 0 00 1");
      fail_cnt++;
    end

  a_vblank_len: assert property (@(posedge clk) disable iff (rst)
      $fell(o_vblank) |-> vb_len == FRAME_GAP)
    else begin
      $error("Mismatch at %0t: o_vblank length exp %0d got %0d",
             $time, FRAME_GAP, $sampled(vb_len));
      fail_cnt++;
    end

  a_sof_width: assert property (@(posedge clk) disable iff (rst) o_sof_stb |=> !o_sof_stb)
    else begin
      $error("Mismatch at %0t: o_sof_stb exp 0 got %b", $time, $sampled(o_sof_stb));
      fail_cnt++;
    end

  a_sof_period: assert property (@(posedge clk) disable iff (rst)
      (o_sof_stb && sof_seen) |-> sof_gap == FRAME_CYCLES)
    else begin
      $error("Mismatch at %0t: o_sof_stb period exp %0d got %0d",
             $time, FRAME_CYCLES, $sampled(sof_gap));
      fail_cnt++;
    end

  a_hsync_width: assert property (@(posedge clk) disable iff (rst)
      $fell(o_video_hsync) |-> hs_len == FRAME_WIDTH)
    else begin
      $error("Mismatch at %0t: o_video_hsync width exp %0d got %0d",
             $time, FRAME_WIDTH, $sampled(hs_len));
      fail_cnt++;
    end

  a_hsync_period: assert property (@(posedge clk) disable iff (rst)
      (o_video_hsync && !hs_q && hs_per != 0) |-> hs_per == LINE_CYCLES)
    else begin
      $error("Mismatch at %0t: o_video_hsync period exp %0d got %0d",
             $time, LINE_CYCLES, $sampled(hs_per));
      fail_cnt++;
    end

  // coordinate follows each pulse, x counts up across the line
  a_pix_coord: assert property (@(posedge clk) disable iff (rst) o_pix_pulse |=>
      (o_nes_x == POS_W'(pix_cnt - 1) && o_nes_y == POS_W'(line_no - Y_OFFSET) &&
       o_nes_y < POS_W'(IMAGE_HEIGHT) && o_nes_y_next == POS_W'(line_no - Y_OFFSET + 1)))
    else begin
      $error("Mismatch at %0t: o_nes_x/y/y_next exp %0d/%0d/%0d got %0d/%0d/%0d", $time,
             $sampled(pix_cnt) - 1, $sampled(line_no) - Y_OFFSET,
             $sampled(line_no) - Y_OFFSET + 1,
             $sampled(o_nes_x), $sampled(o_nes_y), $sampled(o_nes_y_next));
      fail_cnt++;
    end

  a_pix_count: assert property (@(posedge clk) disable iff (rst)
      $fell(o_video_hsync) |-> pix_cnt == line_pixels(line_no))
    else begin
      $error("Mismatch at %0t: o_pix_pulse count on line %0d exp %0d got %0d", $time,
             $sampled(line_no), line_pixels($sampled(line_no)), $sampled(pix_cnt));
      fail_cnt++;
    end

  // two cycles after a pulse the ppu answer is on the bus
  a_rgb_bg: assert property (@(posedge clk) disable iff (rst)
      !pulse_q[1] |-> rgb == BG_COLOR)
    else begin
      $error("Mismatch at %0t: rgb outside the window exp %h got %h",
             $time, BG_COLOR, $sampled(rgb));
      fail_cnt++;
    end

  a_rgb_idx: assert property (@(posedge clk) disable iff (rst)
      (pulse_q[1] && known_idx) |-> rgb == known_rgb(i_sys_palette_idx))
    else begin
      $error("Mismatch at %0t: rgb for idx %h exp %h got %h", $time,
             $sampled(i_sys_palette_idx), known_rgb($sampled(i_sys_palette_idx)),
             $sampled(rgb));
      fail_cnt++;
    end

endmodule

bind nes_lcd_top nes_lcd_chk u_chk (.*);

// File: nes_lcd_top.sv
module nes_lcd_top import nes_video_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic [5:0]       i_sys_palette_idx,  // from the ppu
  output logic [POS_W-1:0] o_nes_x,
  output logic [POS_W-1:0] o_nes_y,
  output logic [POS_W-1:0] o_nes_y_next,
  output logic             o_pix_pulse,
  output logic             o_vblank,
  output logic             o_video_hsync,
  output logic             o_sof_stb,
  output logic [2:0]       o_r,
  output logic [2:0]       o_g,
  output logic [1:0]       o_b
);

  logic start;        // timer to sequencer
  logic raster_done;  // sequencer back to timer
  logic pixel_valid;  // mapper to palette, one cycle late

  raster_if u_ras ();

  frame_timer u_frame_timer (
    .clk           (clk),
    .rst           (rst),
    .i_raster_done (raster_done),
    .o_start       (start)
  );

  raster_sequencer u_raster_sequencer (
    .clk           (clk),
    .rst           (rst),
    .i_start       (start),
    .o_raster_done (raster_done),
    .o_sof_stb     (o_sof_stb),
    .o_video_hsync (o_video_hsync),
    .o_vblank      (o_vblank),
    .ras           (u_ras.sequencer)
  );

  nes_window_map u_nes_window_map (
    .clk           (clk),
    .rst           (rst),
    .ras           (u_ras.mapper),
    .o_nes_x       (o_nes_x),
    .o_nes_y       (o_nes_y),
    .o_nes_y_next  (o_nes_y_next),
    .o_pix_pulse   (o_pix_pulse),
    .o_pixel_valid (pixel_valid)
  );

  nes_palette_rgb u_nes_palette_rgb (
    .i_pixel_valid (pixel_valid),
    .i_palette_idx (i_sys_palette_idx),
    .o_r           (o_r),
    .o_g           (o_g),
    .o_b           (o_b)
  );

endmodule

// File: nes_palette_rgb.sv
module nes_palette_rgb import nes_video_pkg::*; (
  input  logic       i_pixel_valid,
  input  logic [5:0] i_palette_idx,
  output logic [2:0] o_r,
  output logic [2:0] o_g,
  output logic [1:0] o_b
);

  logic [7:0] rgb;  // r, g, b packed 3-3-2

  // approximation of the nes system palette
  always_comb begin
    case (i_palette_idx)
      6'h00: rgb = {3'd3, 3'd3, 2'd1};
      6'h01: rgb = {3'd1, 3'd0, 2'd2};
      6'h02: rgb = {3'd0, 3'd0, 2'd2};
      6'h03: rgb = {3'd2, 3'd0, 2'd2};
      6'h04: rgb = {3'd4, 3'd0, 2'd1};
      6'h05: rgb = {3'd5, 3'd0, 2'd0};
      6'h06: rgb = {3'd5, 3'd0, 2'd0};
      6'h07: rgb = {3'd3, 3'd0, 2'd0};
      6'h08: rgb = {3'd2, 3'd1, 2'd0};
      6'h09: rgb = {3'd0, 3'd2, 2'd0};
      6'h0a: rgb = {3'd0, 3'd2, 2'd0};
      6'h0b: rgb = {3'd0, 3'd1, 2'd0};
      6'h0c: rgb = {3'd0, 3'd1, 2'd1};
      6'h0d: rgb = 8'h00;  // unused columns are black
      6'h0e: rgb = 8'h00;
      6'h0f: rgb = 8'h00;
      6'h10: rgb = {3'd5, 3'd5, 2'd2};
      6'h11: rgb = {3'd0, 3'd3, 2'd3};
      6'h12: rgb = {3'd1, 3'd1, 2'd3};
      6'h13: rgb = {3'd4, 3'd0, 2'd3};
      6'h14: rgb = {3'd5, 3'd0, 2'd2};
      6'h15: rgb = {3'd7, 3'd0, 2'd1};
      6'h16: rgb = {3'd6, 3'd1, 2'd0};
      6'h17: rgb = {3'd6, 3'd2, 2'd0};
      6'h18: rgb = {3'd4, 3'd3, 2'd0};
      6'h19: rgb = {3'd0, 3'd4, 2'd0};
      6'h1a: rgb = {3'd0, 3'd5, 2'd0};
      6'h1b: rgb = {3'd0, 3'd4, 2'd0};
      6'h1c: rgb = {3'd0, 3'd4, 2'd2};
      6'h1d: rgb = 8'h00;
      6'h1e: rgb = 8'h00;
      6'h1f: rgb = 8'h00;
      6'h20: rgb = {3'd7, 3'd7, 2'd3};  // white
      6'h21: rgb = {3'd1, 3'd5, 2'd3};
      6'h22: rgb = {3'd2, 3'd4, 2'd3};
      6'h23: rgb = {3'd5, 3'd4, 2'd3};
      6'h24: rgb = {3'd7, 3'd3, 2'd3};
      6'h25: rgb = {3'd7, 3'd3, 2'd2};
      6'h26: rgb = {3'd7, 3'd3, 2'd1};
      6'h27: rgb = {3'd7, 3'd4, 2'd0};
      6'h28: rgb = {3'd7, 3'd5, 2'd0};
      6'h29: rgb = {3'd4, 3'd6, 2'd0};
      6'h2a: rgb = {3'd2, 3'd6, 2'd1};
      6'h2b: rgb = {3'd2, 3'd7, 2'd2};
      6'h2c: rgb = {3'd0, 3'd7, 2'd3};
      6'h2d: rgb = 8'h00;
      6'h2e: rgb = 8'h00;
      6'h2f: rgb = 8'h00;
      6'h30: rgb = {3'd7, 3'd7, 2'd3};
      6'h31: rgb = {3'd5, 3'd7, 2'd3};
      6'h32: rgb = {3'd6, 3'd6, 2'd3};
      6'h33: rgb = {3'd6, 3'd6, 2'd3};
      6'h34: rgb = {3'd7, 3'd6, 2'd3};
      6'h35: rgb = {3'd7, 3'd6, 2'd3};
      6'h36: rgb = {3'd7, 3'd5, 2'd2};
      6'h37: rgb = {3'd7, 3'd6, 2'd2};
      6'h38: rgb = {3'd7, 3'd7, 2'd2};
      6'h39: rgb = {3'd7, 3'd7, 2'd2};
      6'h3a: rgb = {3'd5, 3'd7, 2'd2};
      6'h3b: rgb = {3'd5, 3'd7, 2'd3};
      6'h3c: rgb = {3'd4, 3'd7, 2'd3};
      6'h3d: rgb = 8'h00;
      6'h3e: rgb = 8'h00;
      6'h3f: rgb = 8'h00;
    endcase
  end

  // border and blanking show the background
  assign {o_r, o_g, o_b} = i_pixel_valid ? rgb : BG_COLOR;

endmodule

// File: nes_video_pkg.sv
package nes_video_pkg;

  // clock and frame rate
  localparam int CLOCK_RATE   = 10_000_000;          // hz
  localparam int FPS          = 60;
  localparam int FRAME_CYCLES = CLOCK_RATE / FPS;    // clocks per displayed frame

  // lcd raster
  localparam int FRAME_WIDTH  = 480;
  localparam int FRAME_HEIGHT = 272;
  localparam int HBLANK       = 100;                 // extra slots per line
  localparam int VBLANK       = 10;                  // extra lines per raster

  localparam int LINE_CYCLES   = FRAME_WIDTH + HBLANK;
  localparam int RASTER_LINES  = FRAME_HEIGHT + VBLANK;
  localparam int RASTER_CYCLES = LINE_CYCLES * RASTER_LINES;

  // idle time left over once the raster has been swept
  localparam int FRAME_GAP = FRAME_CYCLES - RASTER_CYCLES;

  // nes picture, centred in the raster
  localparam int IMAGE_WIDTH  = 256;
  localparam int IMAGE_HEIGHT = 240;
  localparam int X_OFFSET     = 112;
  localparam int Y_OFFSET     = 16;

  // 3-3-2 rgb shown outside the nes window
  localparam logic [7:0] BG_COLOR = 8'h00;  // black

  // counter widths
  localparam int POS_W = 10;  // raster x/y, 580 and 282 fit
  localparam int CNT_W = 12;  // gap counter, 3106 fits

endpackage

// File: nes_window_map.sv
module nes_window_map import nes_video_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  raster_if.mapper         ras,
  output logic [POS_W-1:0] o_nes_x,
  output logic [POS_W-1:0] o_nes_y,
  output logic [POS_W-1:0] o_nes_y_next,
  output logic             o_pix_pulse,
  output logic             o_pixel_valid
);

  logic             x_in;
  logic             y_in;
  logic             in_window;
  logic [POS_W-1:0] x_ahead;
  logic             ahead_in;
  logic [POS_W-1:0] nes_y;

  assign x_in = (ras.x >= POS_W'(X_OFFSET)) && (ras.x < POS_W'(X_OFFSET + IMAGE_WIDTH));
  assign y_in = (ras.y >= POS_W'(Y_OFFSET)) && (ras.y < POS_W'(Y_OFFSET + IMAGE_HEIGHT));

  assign in_window = ras.scan && ras.line_active && x_in && y_in;

  // two slots ahead, since the pulse is registered and leads by one
  // window ends well before the line does, so no wrap to handle
  assign x_ahead  = ras.x + POS_W'(2);
  assign ahead_in = ras.scan && y_in &&
                    (x_ahead >= POS_W'(X_OFFSET)) &&
                    (x_ahead < POS_W'(X_OFFSET + IMAGE_WIDTH));

  assign nes_y        = in_window ? ras.y - POS_W'(Y_OFFSET) : '0;
  assign o_nes_x      = in_window ? ras.x - POS_W'(X_OFFSET) : '0;
  assign o_nes_y      = nes_y;
  assign o_nes_y_next = nes_y + 1'b1;  // ppu prefetch of the next line

  always_ff @(posedge clk) begin
    if (rst) begin
      o_pix_pulse   <= 1'b0;
      o_pixel_valid <= 1'b0;
    end else begin
      o_pix_pulse   <= ahead_in;
      o_pixel_valid <= in_window;  // lines up with the ppu answer
    end
  end

endmodule

// File: raster_if.sv
interface raster_if import nes_video_pkg::*; ();

  logic [POS_W-1:0] x;            // slot within the line
  logic [POS_W-1:0] y;            // line within the raster
  logic             scan;         // sequencer sweeping
  logic             line_active;  // x inside the visible width

  // position source
  modport sequencer (
    output x,
    output y,
    output scan,
    output line_active
  );

  // window decode
  modport mapper (
    input x,
    input y,
    input scan,
    input line_active
  );

endinterface

// File: raster_sequencer.sv
module raster_sequencer import nes_video_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        i_start,
  output logic        o_raster_done,
  output logic        o_sof_stb,
  output logic        o_video_hsync,
  output logic        o_vblank,
  raster_if.sequencer ras
);

  typedef enum logic {
    IDLE,
    SCAN
  } state_t;

  state_t           state;
  logic [POS_W-1:0] x_q;
  logic [POS_W-1:0] y_q;
  logic             scan;
  logic             line_active;
  logic             line_end;
  logic             raster_end;

  assign scan        = (state == SCAN);
  assign line_active = (x_q < POS_W'(FRAME_WIDTH));
  assign line_end    = (x_q == POS_W'(LINE_CYCLES - 1));
  assign raster_end  = scan && line_end && (y_q == POS_W'(RASTER_LINES - 1));

  assign o_raster_done = raster_end;  // last slot of the raster
  assign o_vblank      = ~scan;

  assign ras.x           = x_q;
  assign ras.y           = y_q;
  assign ras.scan        = scan;
  assign ras.line_active = line_active;

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      x_q           <= '0;
      y_q           <= '0;
      o_sof_stb     <= 1'b0;
      o_video_hsync <= 1'b0;
    end else begin
      o_sof_stb     <= 1'b0;
      o_video_hsync <= scan && line_active;  // lags x by one

      case (state)
        IDLE: begin
          if (i_start) begin
            state     <= SCAN;
            x_q       <= '0;
            y_q       <= '0;
            o_sof_stb <= 1'b1;                // high in the first scan cycle
          end
        end

        SCAN: begin
          if (line_end) begin
            x_q <= '0;
            if (raster_end) begin
              y_q   <= '0;
              state <= IDLE;
            end else begin
              y_q <= y_q + 1'b1;
            end
          end else begin
            x_q <= x_q + 1'b1;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: tb_nes_lcd.sv
module tb_nes_lcd import nes_video_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 520_000;  // three frames plus margin

  logic             clk;
  logic             rst;
  logic [5:0]       i_sys_palette_idx;
  logic [POS_W-1:0] o_nes_x;
  logic [POS_W-1:0] o_nes_y;
  logic [POS_W-1:0] o_nes_y_next;
  logic             o_pix_pulse;
  logic             o_vblank;
  logic             o_video_hsync;
  logic             o_sof_stb;
  logic [2:0]       o_r;
  logic [2:0]       o_g;
  logic [1:0]       o_b;

  integer           seed = 78;
  int               cycles = 0;
  int               sof_seen = 0;
  logic [POS_W-1:0] prev_x;
  logic [POS_W-1:0] prev_y;

  nes_lcd_top u_nes_lcd_top (.*);

  always #20 clk = ~clk;

  initial begin
    clk               = 1'b0;
    rst               = 1'b1;
    i_sys_palette_idx = 6'h00;
    prev_x            = '0;
    prev_y            = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  end

  // ppu stand-in, answers for the coordinate of the previous cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (prev_y[2:0] == 3'd0) begin
        case (prev_x % 3)
          0:       i_sys_palette_idx <= 6'h00;
          1:       i_sys_palette_idx <= 6'h20;
          default: i_sys_palette_idx <= 6'h0d;
        endcase
      end else begin
        i_sys_palette_idx <= 6'($random(seed));
      end
      prev_x <= o_nes_x;
      prev_y <= o_nes_y;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (!rst && o_sof_stb)
      sof_seen <= sof_seen + 1;
  end

  initial begin
    wait (u_nes_lcd_top.u_chk.fail_cnt != 0);
    $display("Result: FAILED");
    $fatal(1, "assertion failure in the checker");
  end

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("Result: FAILED");
    $fatal(1, "timeout, only %0d frame starts seen in %0d cycles", sof_seen, cycles);
  end

  initial begin
    wait (sof_seen == 3);
    repeat (4) @(posedge clk);
    if (u_nes_lcd_top.u_chk.fail_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("Result: FAILED");
      $fatal(1, "checker reported failures");
    end
  end

endmodule

// File: verilog.f
nes_video_pkg.sv
raster_if.sv
frame_timer.sv
raster_sequencer.sv
nes_window_map.sv
nes_palette_rgb.sv
nes_lcd_top.sv
nes_lcd_chk.sv
tb_nes_lcd.sv
